// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= pipe_ctrl_tb
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(wildcard hdl/*.sv) $(wildcard testbench/*.sv) $(wildcard include/*.svh)
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides, the simulator status alone does not
run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== all.f ====
+incdir+include
hdl/insn_ctrl_pkg.sv
hdl/insn_decode.sv
hdl/insn_execute.sv
hdl/insn_result.sv
hdl/pipe_ctrl.sv
testbench/pipe_ctrl_asserts.sv
testbench/pipe_ctrl_tb.sv

// ==== hdl/insn_ctrl_pkg.sv ====
// opcode, alu, branch, load/store, write-back source and operand select types
`default_nettype none

`include "insn_ctrl_config.svh"

package insn_ctrl_pkg;

	// major opcodes kept in this slice, bits 31:26
	typedef enum logic [`OPC_W-1:0] {
		OPC_J     = 6'h00, OPC_JAL   = 6'h01, OPC_BNF   = 6'h03, OPC_BF    = 6'h04,
		OPC_NOP   = 6'h05, OPC_MOVHI = 6'h06, OPC_XSYNC = 6'h08, OPC_RFE   = 6'h09,
		OPC_JR    = 6'h11, OPC_JALR  = 6'h12, OPC_LWZ   = 6'h21, OPC_LWS   = 6'h22,
		OPC_LBZ   = 6'h23, OPC_LBS   = 6'h24, OPC_LHZ   = 6'h25, OPC_LHS   = 6'h26,
		OPC_ADDI  = 6'h27, OPC_ADDIC = 6'h28, OPC_ANDI  = 6'h29, OPC_ORI   = 6'h2a,
		OPC_XORI  = 6'h2b, OPC_MFSPR = 6'h2d, OPC_SFXXI = 6'h2f, OPC_MTSPR = 6'h30,
		OPC_SW    = 6'h35, OPC_SB    = 6'h36, OPC_SH    = 6'h37, OPC_ALU   = 6'h38,
		OPC_SFXX  = 6'h39
	} opcode_t;

	// alu operation, sub-ops 0..15 of the alu group map straight through
	typedef enum logic [4:0] {
		ALU_ADD   = 5'd0,  ALU_ADDC  = 5'd1,  ALU_SUB   = 5'd2,  ALU_AND   = 5'd3,
		ALU_OR    = 5'd4,  ALU_XOR   = 5'd5,  ALU_MUL   = 5'd6,  ALU_SHROT = 5'd8,
		ALU_DIV   = 5'd9,  ALU_DIVU  = 5'd10, ALU_MULU  = 5'd11,
		ALU_MOVHI = 5'd16, ALU_COMP  = 5'd17, ALU_NOP   = 5'd31
	} alu_op_t;

	// branch class, pre-decoded in the decode stage
	typedef enum logic [2:0] {
		BR_NOP, BR_J, BR_JR, BR_BNF, BR_BF, BR_RFE
	} branch_op_t;

	// load/store operation
	typedef enum logic [3:0] {
		LSU_NOP, LSU_LWZ, LSU_LWS, LSU_LBZ, LSU_LBS, LSU_LHZ, LSU_LHS,
		LSU_SW, LSU_SB, LSU_SH
	} lsu_op_t;

	// register file write-back source
	typedef enum logic [1:0] {
		WB_ALU, WB_LSU, WB_SPRS, WB_LR
	} wb_src_t;

	// operand source select for the execute operands
	typedef enum logic [1:0] {
		SEL_RF, SEL_EX_FORW, SEL_WB_FORW, SEL_IMM
	} sel_t;

endpackage

`default_nettype wire

// ==== hdl/insn_decode.sv ====
// decode stage: instruction latch, branch and immediate-select regs, imm extension, lsu decode
`timescale 1ns/10ps
`default_nettype none

`include "insn_ctrl_config.svh"

module insn_decode import insn_ctrl_pkg::*; (
	input  logic                clk,
	input  logic                reset,
	input  logic                flush,
	input  logic                id_freeze,
	input  logic [`INSN_W-1:0]  if_insn,
	output logic [`INSN_W-1:0]  id_insn,
	output branch_op_t          id_branch_op,
	output logic                sel_imm,
	output logic [`INSN_W-1:0]  id_simm,
	output lsu_op_t             id_lsu_op,
	output logic                id_void
);

	// major opcodes of the fetched and the latched word
	opcode_t if_opc;
	opcode_t id_opc;

	assign if_opc = opcode_t'(if_insn[`INSN_W-1 -: `OPC_W]);
	assign id_opc = opcode_t'(id_insn[`INSN_W-1 -: `OPC_W]);

	//////////////////////////////////////////////////////////////////////
	// instruction latch and branch pre-decode
	//////////////////////////////////////////////////////////////////////

	// flush turns the slot into a void nop
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			id_insn <= `NOP_INSN;
			id_branch_op <= BR_NOP;
		end else if (!id_freeze) begin
			id_insn <= if_insn;
			case (if_opc)
				OPC_J, OPC_JAL: id_branch_op <= BR_J;
				OPC_JR, OPC_JALR: id_branch_op <= BR_JR;
				OPC_BNF: id_branch_op <= BR_BNF;
				OPC_BF: id_branch_op <= BR_BF;
				OPC_RFE: id_branch_op <= BR_RFE;
				default: id_branch_op <= BR_NOP;
			endcase
		end
	end

	// operand b comes from the immediate
	// flush leaves this alone, the void nop never reads it
	always_ff @(posedge clk) begin
		if (reset) begin
			sel_imm <= 1'b0;
		end else if (!flush && !id_freeze) begin
			case (if_opc)
				OPC_JALR, OPC_JR, OPC_RFE, OPC_MFSPR, OPC_MTSPR, OPC_XSYNC,
				OPC_SW, OPC_SB, OPC_SH, OPC_ALU, OPC_SFXX, OPC_NOP:
					sel_imm <= 1'b0;
				default:
					sel_imm <= 1'b1;
			endcase
		end
	end

	//////////////////////////////////////////////////////////////////////
	// immediate extension
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (id_opc)
			// arithmetic, loads, xori and compares sign-extend
			OPC_ADDI, OPC_ADDIC, OPC_XORI, OPC_SFXXI,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				id_simm = {{(`INSN_W - `IMM_W){id_insn[`IMM_W-1]}}, id_insn[`IMM_W-1:0]};
			// stores carry the offset split around rB
			OPC_SW, OPC_SB, OPC_SH:
				id_simm = {{(`INSN_W - `IMM_W){id_insn[25]}}, id_insn[25:21], id_insn[10:0]};
			// spr number, same split field but unsigned
			OPC_MTSPR:
				id_simm = {{(`INSN_W - `IMM_W){1'b0}}, id_insn[25:21], id_insn[10:0]};
			default:
				id_simm = {{(`INSN_W - `IMM_W){1'b0}}, id_insn[`IMM_W-1:0]};
		endcase
	end

	// load/store op for the lsu
	always_comb begin
		case (id_opc)
			OPC_LWZ: id_lsu_op = LSU_LWZ;
			OPC_LWS: id_lsu_op = LSU_LWS;
			OPC_LBZ: id_lsu_op = LSU_LBZ;
			OPC_LBS: id_lsu_op = LSU_LBS;
			OPC_LHZ: id_lsu_op = LSU_LHZ;
			OPC_LHS: id_lsu_op = LSU_LHS;
			OPC_SW: id_lsu_op = LSU_SW;
			OPC_SB: id_lsu_op = LSU_SB;
			OPC_SH: id_lsu_op = LSU_SH;
			default: id_lsu_op = LSU_NOP;
		endcase
	end

	// void slot marker
	assign id_void = (id_opc == OPC_NOP) && id_insn[16];

endmodule

`default_nettype wire

// ==== hdl/insn_execute.sv ====
// execute stage: instruction latch, registered control decode, bubble insertion
`timescale 1ns/10ps
`default_nettype none

`include "insn_ctrl_config.svh"

module insn_execute import insn_ctrl_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   flush,
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	input  logic [`INSN_W-1:0]     id_insn,
	input  logic [`INSN_W-1:0]     id_simm,
	input  branch_op_t             id_branch_op,
	output logic [`INSN_W-1:0]     ex_insn,
	output logic [`INSN_W-1:0]     ex_simm,
	output alu_op_t                alu_op,
	output logic [`SUBOP_W-1:0]    alu_op2,
	output logic [`SUBOP_W-1:0]    comp_op,
	output wb_src_t                rfwb_src,
	output logic                   rf_we,
	output logic [`REG_ADDR_W-1:0] rf_addrw,
	output logic                   spr_read,
	output logic                   spr_write,
	output logic                   sig_syscall,
	output logic                   sig_trap,
	output logic                   except_illegal,
	output branch_op_t             ex_branch_op
);

	opcode_t id_opc;
	alu_op_t alu_sub;
	logic bubble;

	// next-state decode of id_insn
	alu_op_t d_alu_op;
	wb_src_t d_rfwb_src;
	logic d_rf_we;
	logic d_illegal;

	assign id_opc = opcode_t'(id_insn[`INSN_W-1 -: `OPC_W]);
	// alu group sub-op, low nibble only
	assign alu_sub = alu_op_t'({1'b0, id_insn[3:0]});

	// decode frozen while execute runs, or any flush
	assign bubble = (!ex_freeze && id_freeze) || flush;

	//////////////////////////////////////////////////////////////////////
	// control decode
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		d_alu_op = ALU_NOP;
		d_rfwb_src = WB_ALU;
		d_rf_we = 1'b0;
		d_illegal = 1'b0;
		case (id_opc)
			OPC_JAL, OPC_JALR: begin
				d_rfwb_src = WB_LR;
				d_rf_we = 1'b1;
			end
			OPC_MOVHI: begin
				d_alu_op = ALU_MOVHI;
				d_rf_we = 1'b1;
			end
			OPC_ADDI: begin
				d_alu_op = ALU_ADD;
				d_rf_we = 1'b1;
			end
			OPC_ADDIC: begin
				d_alu_op = ALU_ADDC;
				d_rf_we = 1'b1;
			end
			OPC_ANDI: begin
				d_alu_op = ALU_AND;
				d_rf_we = 1'b1;
			end
			OPC_ORI: begin
				d_alu_op = ALU_OR;
				d_rf_we = 1'b1;
			end
			OPC_XORI: begin
				d_alu_op = ALU_XOR;
				d_rf_we = 1'b1;
			end
			// no multiplier or divider behind this alu
			OPC_ALU: begin
				d_alu_op = alu_sub;
				d_rf_we = 1'b1;
				d_illegal = (alu_sub == ALU_MUL) || (alu_sub == ALU_MULU) ||
					(alu_sub == ALU_DIV) || (alu_sub == ALU_DIVU);
			end
			OPC_SFXX, OPC_SFXXI:
				d_alu_op = ALU_COMP;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS: begin
				d_rfwb_src = WB_LSU;
				d_rf_we = 1'b1;
			end
			OPC_MFSPR: begin
				d_rfwb_src = WB_SPRS;
				d_rf_we = 1'b1;
			end
			// legal, nothing written back
			OPC_J, OPC_BNF, OPC_BF, OPC_NOP, OPC_XSYNC, OPC_RFE, OPC_JR,
			OPC_MTSPR, OPC_SW, OPC_SB, OPC_SH: ;
			// any opcode outside the kept set
			default:
				d_illegal = 1'b1;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// execute registers
	//////////////////////////////////////////////////////////////////////

	// reset and bubble both leave a void nop with quiet strobes
	always_ff @(posedge clk) begin
		if (reset || bubble) begin
			ex_insn <= `NOP_INSN;
			alu_op <= ALU_NOP;
			alu_op2 <= '0;
			comp_op <= '0;
			rfwb_src <= WB_ALU;
			rf_we <= 1'b0;
			rf_addrw <= '0;
			spr_read <= 1'b0;
			spr_write <= 1'b0;
			sig_syscall <= 1'b0;
			sig_trap <= 1'b0;
			except_illegal <= 1'b0;
			ex_branch_op <= BR_NOP;
		end else if (!ex_freeze) begin
			ex_insn <= id_insn;
			alu_op <= d_alu_op;
			alu_op2 <= id_insn[9:6];
			comp_op <= id_insn[24:21];
			rfwb_src <= d_rfwb_src;
			rf_we <= d_rf_we;
			// link register for jal/jalr, rD otherwise
			rf_addrw <= (id_opc == OPC_JAL || id_opc == OPC_JALR) ? `LINK_REG : id_insn[25:21];
			spr_read <= (id_opc == OPC_MFSPR);
			spr_write <= (id_opc == OPC_MTSPR);
			// l.sys and l.trap live in the xsync group
			sig_syscall <= (id_insn[31:23] == {OPC_XSYNC, 3'b000});
			sig_trap <= (id_insn[31:23] == {OPC_XSYNC, 3'b010});
			except_illegal <= d_illegal;
			ex_branch_op <= id_branch_op;
		end
	end

	// immediate just follows the stage, never bubbled
	always_ff @(posedge clk) begin
		if (reset)
			ex_simm <= '0;
		else if (!ex_freeze)
			ex_simm <= id_simm;
	end

endmodule

`default_nettype wire

// ==== hdl/insn_result.sv ====
// write-back stage: instruction and destination latch, operand forwarding selects
`timescale 1ns/10ps
`default_nettype none

`include "insn_ctrl_config.svh"

module insn_result import insn_ctrl_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   wb_freeze,
	input  logic                   wbforw_valid,
	input  logic                   sel_imm,
	input  logic                   rf_we,
	input  logic [`INSN_W-1:0]     ex_insn,
	input  logic [`INSN_W-1:0]     id_insn,
	input  logic [`REG_ADDR_W-1:0] rf_addrw,
	output logic [`INSN_W-1:0]     wb_insn,
	output sel_t                   sel_a,
	output sel_t                   sel_b
);

	// destination of the write-back instruction
	logic [`REG_ADDR_W-1:0] wb_rfaddrw;

	// execute result wins over write-back result
	function automatic sel_t fwd_sel(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == rf_addrw && rf_we)
			return SEL_EX_FORW;
		else if (addr == wb_rfaddrw && wbforw_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	// flush does not touch wb_insn, the trace still sees what retired
	always_ff @(posedge clk) begin
		if (reset) begin
			wb_insn <= `NOP_INSN;
			wb_rfaddrw <= '0;
		end else if (!wb_freeze) begin
			wb_insn <= ex_insn;
			wb_rfaddrw <= rf_addrw;
		end
	end

	// rA and rB of the instruction in decode
	assign sel_a = fwd_sel(id_insn[20:16]);
	assign sel_b = sel_imm ? SEL_IMM : fwd_sel(id_insn[15:11]);

endmodule

`default_nettype wire

// ==== hdl/pipe_ctrl.sv ====
// instruction-control top: flush merge, register file read ports, decode/execute/result stages
`timescale 1ns/10ps
`default_nettype none

`include "insn_ctrl_config.svh"

module pipe_ctrl import insn_ctrl_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [`INSN_W-1:0]     if_insn,
	input  logic                   id_freeze,
	input  logic                   ex_freeze,
	input  logic                   wb_freeze,
	input  logic                   except_flush,
	input  logic                   pc_we,
	input  logic                   du_flush,
	input  logic                   wbforw_valid,
	output logic [`INSN_W-1:0]     id_insn,
	output logic [`INSN_W-1:0]     ex_insn,
	output logic [`INSN_W-1:0]     wb_insn,
	output logic [`INSN_W-1:0]     id_simm,
	output logic [`INSN_W-1:0]     ex_simm,
	output logic                   id_void,
	output branch_op_t             id_branch_op,
	output branch_op_t             ex_branch_op,
	output lsu_op_t                id_lsu_op,
	output alu_op_t                alu_op,
	output logic [`SUBOP_W-1:0]    alu_op2,
	output logic [`SUBOP_W-1:0]    comp_op,
	output wb_src_t                rfwb_src,
	output logic                   rf_we,
	output logic [`REG_ADDR_W-1:0] rf_addrw,
	output logic [`REG_ADDR_W-1:0] rf_addra,
	output logic [`REG_ADDR_W-1:0] rf_addrb,
	output logic                   rf_rda,
	output logic                   rf_rdb,
	output sel_t                   sel_a,
	output sel_t                   sel_b,
	output logic                   spr_read,
	output logic                   spr_write,
	output logic                   sig_syscall,
	output logic                   sig_trap,
	output logic                   except_illegal,
	output logic                   flushpipe
);

	// decode to result, operand b source
	logic sel_imm;

	// exception, pc write or debug unit
	assign flushpipe = except_flush || pc_we || du_flush;

	// rf read straight off the fetched word
	assign rf_addra = if_insn[20:16];
	assign rf_addrb = if_insn[15:11];
	assign rf_rda = if_insn[31];
	assign rf_rdb = if_insn[30];

	insn_decode u_decode (
		.clk          (clk),
		.reset        (reset),
		.flush        (flushpipe),
		.id_freeze    (id_freeze),
		.if_insn      (if_insn),
		.id_insn      (id_insn),
		.id_branch_op (id_branch_op),
		.sel_imm      (sel_imm),
		.id_simm      (id_simm),
		.id_lsu_op    (id_lsu_op),
		.id_void      (id_void)
	);

	insn_execute u_execute (
		.clk            (clk),
		.reset          (reset),
		.flush          (flushpipe),
		.id_freeze      (id_freeze),
		.ex_freeze      (ex_freeze),
		.id_insn        (id_insn),
		.id_simm        (id_simm),
		.id_branch_op   (id_branch_op),
		.ex_insn        (ex_insn),
		.ex_simm        (ex_simm),
		.alu_op         (alu_op),
		.alu_op2        (alu_op2),
		.comp_op        (comp_op),
		.rfwb_src       (rfwb_src),
		.rf_we          (rf_we),
		.rf_addrw       (rf_addrw),
		.spr_read       (spr_read),
		.spr_write      (spr_write),
		.sig_syscall    (sig_syscall),
		.sig_trap       (sig_trap),
		.except_illegal (except_illegal),
		.ex_branch_op   (ex_branch_op)
	);

	insn_result u_result (
		.clk          (clk),
		.reset        (reset),
		.wb_freeze    (wb_freeze),
		.wbforw_valid (wbforw_valid),
		.sel_imm      (sel_imm),
		.rf_we        (rf_we),
		.ex_insn      (ex_insn),
		.id_insn      (id_insn),
		.rf_addrw     (rf_addrw),
		.wb_insn      (wb_insn),
		.sel_a        (sel_a),
		.sel_b        (sel_b)
	);

endmodule

`default_nettype wire

// ==== include/insn_ctrl_config.svh ====
// instruction field widths, link register number and the void nop word
`ifndef INSN_CTRL_CONFIG_SVH
`define INSN_CTRL_CONFIG_SVH

// instruction word and register file
`define INSN_W       32
`define REG_ADDR_W   5

// major opcode field, top of the word
`define OPC_W        6

// 16-bit immediate field
`define IMM_W        16

// comp_op and alu_op2 sub fields
`define SUBOP_W      4

// jal/jalr write the return address here
`define LINK_REG     5'd9

// nop opcode with bit 16 set marks a void slot
`define NOP_INSN     32'h1441_0000

`endif

// ==== testbench/pipe_ctrl_asserts.sv ====
// concurrent checks on flush, bubble and reset behavior, bound into the execute stage
`timescale 1ns/10ps
`default_nettype none

`include "insn_ctrl_config.svh"

module pipe_ctrl_asserts import insn_ctrl_pkg::*; (
	input logic clk,
	input logic reset,
	input logic flush,
	input logic id_freeze,
	input logic ex_freeze,
	input logic [`INSN_W-1:0] id_insn,
	input logic [`INSN_W-1:0] ex_insn,
	input alu_op_t alu_op,
	input logic rf_we,
	input logic spr_read,
	input logic spr_write,
	input logic sig_syscall,
	input logic sig_trap,
	input logic except_illegal
);

	// id_insn here is the decode latch as execute sees it
	flush_voids: assert property (@(posedge clk)
		flush |=> (id_insn == `NOP_INSN) && (ex_insn == `NOP_INSN))
		else $error("flush did not leave void nops in decode and execute");

	// decode held while execute runs
	bubble_quiet: assert property (@(posedge clk)
		(flush || (id_freeze && !ex_freeze)) |=> (alu_op == ALU_NOP) && !rf_we)
		else $error("bubble left alu_op or rf_we active");

	reset_quiet: assert property (@(posedge clk)
		reset |=> !(rf_we || spr_read || spr_write || sig_syscall || sig_trap || except_illegal))
		else $error("strobes not low after reset");

endmodule

bind insn_execute pipe_ctrl_asserts ex_checks (
	.clk            (clk),
	.reset          (reset),
	.flush          (flush),
	.id_freeze      (id_freeze),
	.ex_freeze      (ex_freeze),
	.id_insn        (id_insn),
	.ex_insn        (ex_insn),
	.alu_op         (alu_op),
	.rf_we          (rf_we),
	.spr_read       (spr_read),
	.spr_write      (spr_write),
	.sig_syscall    (sig_syscall),
	.sig_trap       (sig_trap),
	.except_illegal (except_illegal)
);

`default_nettype wire

// ==== testbench/pipe_ctrl_tb.sv ====
// testbench for the instruction-control pipeline: stimulus table, stage model, compare tasks, timeout
`timescale 1ns/10ps
`default_nettype none

`include "insn_ctrl_config.svh"

module pipe_ctrl_tb import insn_ctrl_pkg::*; ();

	// one table row: fetched word, control levels, expected illegal flag
	typedef struct packed {
		logic [`INSN_W-1:0] insn;
		logic id_frz;
		logic ex_frz;
		logic wb_frz;
		logic exc;
		logic pcw;
		logic duf;
		logic wbv;
		logic ill;
	} row_t;

	// flag bits for the rows, or'ed together
	localparam logic [7:0] plain = 8'h00;
	localparam logic [7:0] is_ill = 8'h01;
	localparam logic [7:0] wb_valid = 8'h02;
	localparam logic [7:0] fl_du = 8'h04;
	localparam logic [7:0] fl_pc = 8'h08;
	localparam logic [7:0] fl_exc = 8'h10;
	localparam logic [7:0] hold_wb = 8'h20;
	localparam logic [7:0] hold_ex = 8'h40;
	localparam logic [7:0] hold_id = 8'h80;

	logic clk = 1'b0;
	logic reset;
	logic [`INSN_W-1:0] if_insn;
	logic id_freeze;
	logic ex_freeze;
	logic wb_freeze;
	logic except_flush;
	logic pc_we;
	logic du_flush;
	logic wbforw_valid;

	logic [`INSN_W-1:0] id_insn;
	logic [`INSN_W-1:0] ex_insn;
	logic [`INSN_W-1:0] wb_insn;
	logic [`INSN_W-1:0] id_simm;
	logic [`INSN_W-1:0] ex_simm;
	logic id_void;
	branch_op_t id_branch_op;
	branch_op_t ex_branch_op;
	lsu_op_t id_lsu_op;
	alu_op_t alu_op;
	logic [`SUBOP_W-1:0] alu_op2;
	logic [`SUBOP_W-1:0] comp_op;
	wb_src_t rfwb_src;
	logic rf_we;
	logic [`REG_ADDR_W-1:0] rf_addrw;
	logic [`REG_ADDR_W-1:0] rf_addra;
	logic [`REG_ADDR_W-1:0] rf_addrb;
	logic rf_rda;
	logic rf_rdb;
	sel_t sel_a;
	sel_t sel_b;
	logic spr_read;
	logic spr_write;
	logic sig_syscall;
	logic sig_trap;
	logic except_illegal;
	logic flushpipe;

	row_t tbl[$];
	int cycles = 0;
	int limit = 0;

	// model copy of the three stages
	logic [`INSN_W-1:0] m_id_insn;
	branch_op_t m_id_br;
	logic m_sel_imm;
	logic m_id_ill;
	logic [`INSN_W-1:0] m_ex_insn;
	logic [`INSN_W-1:0] m_ex_simm;
	alu_op_t m_alu;
	logic [`SUBOP_W-1:0] m_alu2;
	logic [`SUBOP_W-1:0] m_comp;
	wb_src_t m_wbsrc;
	logic m_we;
	logic [`REG_ADDR_W-1:0] m_addrw;
	logic m_sprr;
	logic m_sprw;
	logic m_sys;
	logic m_trap;
	logic m_ill;
	branch_op_t m_ex_br;
	logic [`INSN_W-1:0] m_wb_insn;
	logic [`REG_ADDR_W-1:0] m_wb_addrw;

	pipe_ctrl uut (.*);

	always #10 clk = ~clk;

	// run limit, table plus reset plus margin
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit != 0 && cycles >= limit) begin
			$display("run timed out after %0d cycles without finishing the table", cycles);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference rules
	//////////////////////////////////////////////////////////////////////

	function automatic logic [`INSN_W-1:0] extend_imm(input logic [`INSN_W-1:0] insn);
		logic [15:0] split;
		split = {insn[25:21], insn[10:0]};
		case (insn[31:26])
			OPC_ADDI, OPC_ADDIC, OPC_XORI, OPC_SFXXI,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				return {{16{insn[15]}}, insn[15:0]};
			OPC_SW, OPC_SB, OPC_SH:
				return {{16{split[15]}}, split};
			OPC_MTSPR:
				return {16'h0000, split};
			default:
				return {16'h0000, insn[15:0]};
		endcase
	endfunction

	function automatic lsu_op_t lsu_decode(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_LWZ: return LSU_LWZ;
			OPC_LWS: return LSU_LWS;
			OPC_LBZ: return LSU_LBZ;
			OPC_LBS: return LSU_LBS;
			OPC_LHZ: return LSU_LHZ;
			OPC_LHS: return LSU_LHS;
			OPC_SW: return LSU_SW;
			OPC_SB: return LSU_SB;
			OPC_SH: return LSU_SH;
			default: return LSU_NOP;
		endcase
	endfunction

	function automatic branch_op_t branch_class(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_J, OPC_JAL: return BR_J;
			OPC_JR, OPC_JALR: return BR_JR;
			OPC_BNF: return BR_BNF;
			OPC_BF: return BR_BF;
			OPC_RFE: return BR_RFE;
			default: return BR_NOP;
		endcase
	endfunction

	// operand b is a register only for this set
	function automatic logic uses_imm(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_JALR, OPC_JR, OPC_RFE, OPC_MFSPR, OPC_MTSPR, OPC_XSYNC,
			OPC_SW, OPC_SB, OPC_SH, OPC_ALU, OPC_SFXX, OPC_NOP:
				return 1'b0;
			default:
				return 1'b1;
		endcase
	endfunction

	function automatic alu_op_t alu_decode(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_MOVHI: return ALU_MOVHI;
			OPC_ADDI: return ALU_ADD;
			OPC_ADDIC: return ALU_ADDC;
			OPC_ANDI: return ALU_AND;
			OPC_ORI: return ALU_OR;
			OPC_XORI: return ALU_XOR;
			OPC_ALU: return alu_op_t'({1'b0, insn[3:0]});
			OPC_SFXX, OPC_SFXXI: return ALU_COMP;
			default: return ALU_NOP;
		endcase
	endfunction

	function automatic wb_src_t wb_source(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_JAL, OPC_JALR: return WB_LR;
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS: return WB_LSU;
			OPC_MFSPR: return WB_SPRS;
			default: return WB_ALU;
		endcase
	endfunction

	function automatic logic writes_reg(input logic [`INSN_W-1:0] insn);
		case (insn[31:26])
			OPC_JAL, OPC_JALR, OPC_MOVHI, OPC_ADDI, OPC_ADDIC, OPC_ANDI, OPC_ORI,
			OPC_XORI, OPC_ALU, OPC_MFSPR,
			OPC_LWZ, OPC_LWS, OPC_LBZ, OPC_LBS, OPC_LHZ, OPC_LHS:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// execute result first, then write-back, else register file
	function automatic sel_t forward_select(input logic [`REG_ADDR_W-1:0] addr);
		if (addr == m_addrw && m_we)
			return SEL_EX_FORW;
		else if (addr == m_wb_addrw && wbforw_valid)
			return SEL_WB_FORW;
		else
			return SEL_RF;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// compare tasks
	//////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("[FAIL] %s got 0x%h expected 0x%h", name, got, exp);
		$display(">>> FAIL");
		$fatal(1, "output mismatch");
	endtask

	task automatic check_word(input string name, input logic [`INSN_W-1:0] got,
		input logic [`INSN_W-1:0] exp);
		if (got !== exp)
			report_mismatch(name, got, exp);
	endtask

	task automatic check_alu(input string name, input alu_op_t got, input alu_op_t exp);
		if (got !== exp)
			report_mismatch(name, {27'd0, got}, {27'd0, exp});
	endtask

	task automatic check_branch(input string name, input branch_op_t got, input branch_op_t exp);
		if (got !== exp)
			report_mismatch(name, {29'd0, got}, {29'd0, exp});
	endtask

	task automatic check_lsu(input string name, input lsu_op_t got, input lsu_op_t exp);
		if (got !== exp)
			report_mismatch(name, {28'd0, got}, {28'd0, exp});
	endtask

	task automatic check_wbsrc(input string name, input wb_src_t got, input wb_src_t exp);
		if (got !== exp)
			report_mismatch(name, {30'd0, got}, {30'd0, exp});
	endtask

	task automatic check_sel(input string name, input sel_t got, input sel_t exp);
		if (got !== exp)
			report_mismatch(name, {30'd0, got}, {30'd0, exp});
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			report_mismatch(name, {31'd0, got}, {31'd0, exp});
	endtask

	task automatic check_outputs();
		check_word("id_insn", id_insn, m_id_insn);
		check_word("ex_insn", ex_insn, m_ex_insn);
		check_word("wb_insn", wb_insn, m_wb_insn);
		check_word("id_simm", id_simm, extend_imm(m_id_insn));
		check_word("ex_simm", ex_simm, m_ex_simm);
		check_bit("id_void", id_void, (m_id_insn[31:26] == OPC_NOP) && m_id_insn[16]);
		check_branch("id_branch_op", id_branch_op, m_id_br);
		check_branch("ex_branch_op", ex_branch_op, m_ex_br);
		check_lsu("id_lsu_op", id_lsu_op, lsu_decode(m_id_insn));
		check_alu("alu_op", alu_op, m_alu);
		check_word("alu_op2", {28'd0, alu_op2}, {28'd0, m_alu2});
		check_word("comp_op", {28'd0, comp_op}, {28'd0, m_comp});
		check_wbsrc("rfwb_src", rfwb_src, m_wbsrc);
		check_bit("rf_we", rf_we, m_we);
		check_word("rf_addrw", {27'd0, rf_addrw}, {27'd0, m_addrw});
		check_bit("spr_read", spr_read, m_sprr);
		check_bit("spr_write", spr_write, m_sprw);
		check_bit("sig_syscall", sig_syscall, m_sys);
		check_bit("sig_trap", sig_trap, m_trap);
		check_bit("except_illegal", except_illegal, m_ill);
		check_sel("sel_a", sel_a, forward_select(m_id_insn[20:16]));
		check_sel("sel_b", sel_b, m_sel_imm ? SEL_IMM : forward_select(m_id_insn[15:11]));
		check_bit("flushpipe", flushpipe, except_flush | pc_we | du_flush);
		// read ports come straight off the fetched word
		check_word("rf_addra", {27'd0, rf_addra}, {27'd0, if_insn[20:16]});
		check_word("rf_addrb", {27'd0, rf_addrb}, {27'd0, if_insn[15:11]});
		check_bit("rf_rda", rf_rda, if_insn[31]);
		check_bit("rf_rdb", rf_rdb, if_insn[30]);
	endtask

	//////////////////////////////////////////////////////////////////////
	// stage model
	//////////////////////////////////////////////////////////////////////

	task automatic reset_model();
		m_id_insn = `NOP_INSN;
		m_id_br = BR_NOP;
		m_sel_imm = 1'b0;
		m_id_ill = 1'b0;
		m_ex_insn = `NOP_INSN;
		m_ex_simm = '0;
		m_alu = ALU_NOP;
		m_alu2 = '0;
		m_comp = '0;
		m_wbsrc = WB_ALU;
		m_we = 1'b0;
		m_addrw = '0;
		m_sprr = 1'b0;
		m_sprw = 1'b0;
		m_sys = 1'b0;
		m_trap = 1'b0;
		m_ill = 1'b0;
		m_ex_br = BR_NOP;
		m_wb_insn = `NOP_INSN;
		m_wb_addrw = '0;
	endtask

	// one clock edge, back stage first so each reads the old state
	task automatic step_model(input row_t r);
		logic flush;
		logic bubble;
		logic is_link;
		flush = r.exc | r.pcw | r.duf;
		bubble = (!r.ex_frz && r.id_frz) || flush;
		is_link = (m_id_insn[31:26] == OPC_JAL) || (m_id_insn[31:26] == OPC_JALR);
		if (!r.wb_frz) begin
			m_wb_insn = m_ex_insn;
			m_wb_addrw = m_addrw;
		end
		if (!r.ex_frz)
			m_ex_simm = extend_imm(m_id_insn);
		if (bubble) begin
			m_ex_insn = `NOP_INSN;
			m_alu = ALU_NOP;
			m_alu2 = '0;
			m_comp = '0;
			m_wbsrc = WB_ALU;
			m_we = 1'b0;
			m_addrw = '0;
			m_sprr = 1'b0;
			m_sprw = 1'b0;
			m_sys = 1'b0;
			m_trap = 1'b0;
			m_ill = 1'b0;
			m_ex_br = BR_NOP;
		end else if (!r.ex_frz) begin
			m_ex_insn = m_id_insn;
			m_alu = alu_decode(m_id_insn);
			m_alu2 = m_id_insn[9:6];
			m_comp = m_id_insn[24:21];
			m_wbsrc = wb_source(m_id_insn);
			m_we = writes_reg(m_id_insn);
			m_addrw = is_link ? `LINK_REG : m_id_insn[25:21];
			m_sprr = (m_id_insn[31:26] == OPC_MFSPR);
			m_sprw = (m_id_insn[31:26] == OPC_MTSPR);
			m_sys = (m_id_insn[31:23] == {6'h08, 3'b000});
			m_trap = (m_id_insn[31:23] == {6'h08, 3'b010});
			m_ill = m_id_ill;
			m_ex_br = m_id_br;
		end
		// sel_imm keeps its value across a flush
		if (flush) begin
			m_id_insn = `NOP_INSN;
			m_id_br = BR_NOP;
			m_id_ill = 1'b0;
		end else if (!r.id_frz) begin
			m_id_insn = r.insn;
			m_id_br = branch_class(r.insn);
			m_sel_imm = uses_imm(r.insn);
			m_id_ill = r.ill;
		end
	endtask

	task automatic apply_row(input row_t r);
		if_insn = r.insn;
		id_freeze = r.id_frz;
		ex_freeze = r.ex_frz;
		wb_freeze = r.wb_frz;
		except_flush = r.exc;
		pc_we = r.pcw;
		du_flush = r.duf;
		wbforw_valid = r.wbv;
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus table
	//////////////////////////////////////////////////////////////////////

	task automatic add_row(input logic [`INSN_W-1:0] insn, input logic [7:0] flags);
		tbl.push_back(row_t'({insn, flags}));
	endtask

	task automatic fill_table();
		// forwarding chain
		add_row({OPC_ADDI, 5'd3, 5'd1, 16'hfffb}, plain);
		// r3 from execute on both operands
		add_row({OPC_ALU, 5'd4, 5'd3, 5'd3, 11'h000}, plain);
		// r3 from write-back, r4 from execute
		add_row({OPC_ALU, 5'd5, 5'd3, 5'd4, 11'h000}, wb_valid);
		add_row({OPC_ALU, 5'd6, 5'd4, 5'd3, 11'h001}, plain);
		add_row({OPC_ORI, 5'd6, 5'd6, 16'h8001}, plain);
		// r6 in both later stages, execute wins
		add_row({OPC_ALU, 5'd8, 5'd6, 5'd6, 11'h002}, wb_valid);
		// store field looks like r8 but writes nothing
		add_row({OPC_SW, 5'd8, 5'd2, 5'd6, 11'h7f0}, plain);
		add_row({OPC_SFXXI, 5'd3, 5'd8, 16'h8000}, plain);
		add_row({OPC_JAL, 26'h000_0010}, plain);
		add_row({OPC_ALU, 5'd1, 5'd9, 5'd0, 11'h000}, plain);
		// immediates and load/store ops
		add_row({OPC_SW, 5'd17, 5'd2, 5'd6, 11'h7f0}, plain);
		add_row({OPC_SB, 5'd3, 5'd2, 5'd6, 11'h400}, plain);
		add_row({OPC_SH, 5'd31, 5'd2, 5'd6, 11'h001}, plain);
		add_row({OPC_MTSPR, 5'd18, 5'd0, 5'd4, 11'h123}, plain);
		add_row({OPC_LWZ, 5'd5, 5'd2, 16'h7ffc}, plain);
		add_row({OPC_LWS, 5'd5, 5'd2, 16'h8004}, plain);
		add_row({OPC_LBZ, 5'd7, 5'd5, 16'h0010}, wb_valid);
		add_row({OPC_LBS, 5'd7, 5'd5, 16'hff80}, plain);
		add_row({OPC_LHZ, 5'd10, 5'd7, 16'h0002}, plain);
		add_row({OPC_LHS, 5'd11, 5'd7, 16'h8002}, plain);
		add_row({OPC_ANDI, 5'd12, 5'd1, 16'h8001}, plain);
		add_row({OPC_ADDIC, 5'd12, 5'd12, 16'hffff}, plain);
		add_row({OPC_XORI, 5'd13, 5'd12, 16'h8fff}, wb_valid);
		// execute decode
		add_row({OPC_MOVHI, 5'd12, 5'd0, 16'hbeef}, plain);
		add_row({OPC_MFSPR, 5'd13, 5'd2, 16'h0011}, plain);
		add_row({OPC_SFXX, 5'd3, 5'd4, 5'd5, 11'h000}, plain);
		add_row({OPC_ALU, 5'd9, 5'd1, 5'd2, 2'b00, 4'hc, 1'b0, 4'h8}, plain);
		add_row({OPC_ALU, 5'd14, 5'd1, 5'd2, 11'h007}, plain);
		add_row({OPC_JALR, 5'd0, 5'd0, 5'd11, 11'h000}, plain);
		add_row({OPC_JR, 5'd0, 5'd0, 5'd9, 11'h000}, plain);
		add_row({OPC_J, 26'h3ff_fff0}, plain);
		add_row({OPC_BNF, 26'h000_0004}, plain);
		add_row({OPC_BF, 26'h3ff_fffc}, plain);
		add_row({OPC_RFE, 26'h000_0000}, plain);
		// syscall, trap, then a plain sync
		add_row({OPC_XSYNC, 3'b000, 23'h00_0010}, plain);
		add_row({OPC_XSYNC, 3'b010, 23'h00_0000}, plain);
		add_row({OPC_XSYNC, 3'b100, 23'h00_0000}, plain);
		add_row({OPC_NOP, 26'h000_0000}, plain);
		// illegal opcodes and mul/div sub-ops
		add_row({6'h3f, 26'h000_0000}, is_ill);
		add_row({6'h07, 26'h012_3456}, is_ill);
		add_row({OPC_ALU, 5'd4, 5'd1, 5'd2, 11'h006}, is_ill);
		add_row({OPC_ALU, 5'd4, 5'd1, 5'd2, 11'h009}, is_ill);
		add_row({OPC_ALU, 5'd4, 5'd1, 5'd2, 11'h00a}, is_ill);
		add_row({OPC_ALU, 5'd4, 5'd1, 5'd2, 11'h00b}, is_ill);
		// each flush source
		add_row({OPC_ADDI, 5'd2, 5'd2, 16'h0001}, fl_exc);
		add_row({OPC_MFSPR, 5'd2, 5'd2, 16'h0001}, plain);
		add_row({OPC_ADDI, 5'd3, 5'd2, 16'h0002}, fl_pc);
		add_row({OPC_XSYNC, 3'b000, 23'h00_0000}, plain);
		add_row({OPC_ORI, 5'd4, 5'd3, 16'h0003}, fl_du | hold_id);
		// freezes
		add_row({OPC_ADDI, 5'd5, 5'd4, 16'h0004}, plain);
		add_row({OPC_ALU, 5'd6, 5'd5, 5'd5, 11'h000}, hold_id);
		add_row({OPC_ALU, 5'd7, 5'd6, 5'd5, 11'h000}, hold_id);
		add_row({OPC_MTSPR, 5'd1, 5'd2, 5'd3, 11'h004}, plain);
		add_row({OPC_LWZ, 5'd8, 5'd1, 16'h0008}, hold_id | hold_ex | hold_wb | wb_valid);
		add_row({OPC_LWZ, 5'd8, 5'd1, 16'h000c}, hold_id | hold_ex | hold_wb);
		add_row({OPC_SB, 5'd8, 5'd1, 5'd2, 11'h00c}, hold_ex);
		add_row({OPC_ADDI, 5'd9, 5'd8, 16'h0001}, hold_wb);
		add_row({OPC_ALU, 5'd10, 5'd9, 5'd8, 11'h000}, hold_wb | wb_valid);
		// drain
		add_row({OPC_NOP, 26'h001_0000}, plain);
		add_row({OPC_NOP, 26'h000_0000}, plain);
		add_row({OPC_NOP, 26'h001_0000}, plain);
	endtask

	initial begin
		reset = 1'b1;
		if_insn = '0;
		id_freeze = 1'b0;
		ex_freeze = 1'b0;
		wb_freeze = 1'b0;
		except_flush = 1'b0;
		pc_we = 1'b0;
		du_flush = 1'b0;
		wbforw_valid = 1'b0;
		fill_table();
		limit = tbl.size() + 16 + 20;
		reset_model();
		repeat (16) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		// check what the last edge left, then drive the next row
		foreach (tbl[i]) begin
			check_outputs();
			apply_row(tbl[i]);
			@(posedge clk);
			step_model(tbl[i]);
			@(negedge clk);
		end
		check_outputs();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire
